// ==== itch_stim.txt ====
// beat b start len data with start 0 continue 1 new message 2 new message without idle
// expected e type locate tracking time order_ref shares match side stock price event
// d ends the stimulus
// system event in two aligned beats
b 1 8 0706050403020153
b 0 4 0b0a0908
e 53 0102 0304 05060708090a 0 0 0 0 0 0 0b
// order delete with beats crossing words
b 1 3 121144
b 0 6 181716151413
b 0 1 19
b 0 7 201f1e1d1c1b1a
b 0 2 2221
e 44 1112 1314 15161718191a 1b1c1d1e1f202122 0 0 0 0 0 0
// unknown type Z gives no output
b 1 8 070605040302015a
b 0 2 0908
// order executed with single byte beats
b 1 1 45
b 0 1 21
b 0 1 22
b 0 8 2a29282726252423
b 0 8 3231302f2e2d2c2b
b 0 7 39383736353433
b 0 5 3e3d3c3b3a
e 45 2122 2324 25262728292a 2b2c2d2e2f303132 33343536
  3738393a3b3c3d3e 0 0 0 0
// add order starting while the executed message is on the outputs
b 2 5 4443424141
b 0 8 4c4b4a4948474645
b 0 8 54535251504f4e4d
b 0 8 5c5b5a5958575655
b 0 7 636261605f5e5d
e 41 4142 4344 45464748494a 4b4c4d4e4f505152 54555657
  0 53 58595a5b5c5d5e5f 60616263 0
d

// ==== compile.f ====
itch_pkg.sv
itch_if.sv
itch_beat_aligner.sv
itch_msg_assembler.sv
itch_msg_decoder.sv
itch_decoder_top.sv
tb_clock.sv
tb_checker.sv
tb_top.sv

// ==== Makefile ====
VERILATOR  ?= verilator
FLAGS      ?= --binary --timing --assert --timescale 1ns/1ps -j 0
LINT_FLAGS ?= --lint-only -Wall --timing --timescale 1ns/1ps
TOP        ?= tb_top
FILELIST   ?= compile.f

BIN      := obj_dir/V$(TOP)
SRCS     := $(shell grep -v '^+' $(FILELIST))
PASS_MSG := Result: PASSED

.PHONY: all run lint clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qF "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir

// ==== tb_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_top;

	localparam int AXI_DATA_W = 64;
	localparam int LEN_W      = $clog2(AXI_DATA_W / 8) + 1;
	localparam int NFIELDS    = 11;

	logic                     clk;
	logic                     nreset;
	logic                     valid;
	logic                     start;
	logic [LEN_W-1:0]         len;
	logic [AXI_DATA_W-1:0]    data;
	logic                     msg_v;
	itch_pkg::itch_msg_e      msg_type;
	logic [15:0]              stock_locate;
	logic [15:0]              tracking_number;
	logic [47:0]              timestamp;
	logic [63:0]              order_ref;
	logic [31:0]              shares;
	logic [63:0]              match_number;
	logic [7:0]               buy_sell;
	logic [63:0]              stock;
	logic [31:0]              price;
	logic [7:0]               event_code;
	logic [NFIELDS-1:0][63:0] act;
	logic [NFIELDS-1:0][63:0] exp_rec;
	logic                     exp_push;
	logic [63:0]              stim [0:255];
	logic [31:0]              rng;
	int                       mismatch_cnt;
	int                       missing_cnt;
	int                       extra_cnt;
	int                       resolved_cnt;

	tb_clock #(.PERIOD_NS(10), .RESET_CYCLES(2)) u_clock (.clk_o(clk), .nreset_o(nreset));

	itch_decoder_top #(.AXI_DATA_W(AXI_DATA_W)) dut (
		.clk(clk), .nreset(nreset), .valid_i(valid), .start_i(start), .len_i(len),
		.data_i(data), .msg_v_o(msg_v), .msg_type_o(msg_type),
		.stock_locate_o(stock_locate), .tracking_number_o(tracking_number),
		.timestamp_o(timestamp), .order_ref_o(order_ref), .shares_o(shares),
		.match_number_o(match_number), .buy_sell_o(buy_sell), .stock_o(stock),
		.price_o(price), .event_code_o(event_code)
	);

	// field order follows the expected records in the stim file
	assign act = {64'(event_code), 64'(price), 64'(stock), 64'(buy_sell),
		64'(match_number), 64'(shares), 64'(order_ref), 64'(timestamp),
		64'(tracking_number), 64'(stock_locate), 64'(msg_type)};

	tb_checker #(.NFIELDS(NFIELDS)) u_checker (
		.clk(clk), .nreset(nreset), .msg_v_i(msg_v), .act_i(act),
		.exp_push_i(exp_push), .exp_rec_i(exp_rec), .mismatch_cnt_o(mismatch_cnt),
		.missing_cnt_o(missing_cnt), .extra_cnt_o(extra_cnt), .resolved_cnt_o(resolved_cnt)
	);

	function automatic logic [31:0] next_random(input logic [31:0] x);
		logic [31:0] s;
		s = x ^ (x << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		return s;
	endfunction

	task automatic idle_cycle();
		@(negedge clk);
		exp_push = 1'b0;
		valid    = 1'b0;
		start    = 1'b0;
	endtask

	task automatic drive_beat(input logic st, input logic [LEN_W-1:0] n, input logic [63:0] d);
		@(negedge clk);
		exp_push = 1'b0;
		valid    = 1'b1;
		start    = st;
		len      = n;
		data     = d;
	endtask

	initial begin
		int          pos;
		int          pushed;
		int          t;
		logic [63:0] kind;
		bit          done;
		bit          fail;
		valid    = 1'b0;
		start    = 1'b0;
		len      = '0;
		data     = '0;
		exp_push = 1'b0;
		exp_rec  = '0;
		rng      = 32'h66c4_239f;
		pos      = 0;
		pushed   = 0;
		done     = 1'b0;
		fail     = 1'b0;
		$readmemh("itch_stim.txt", stim);
		@(negedge clk);
		t = 0;
		while (nreset !== 1'b0 && t < 20) begin
			@(negedge clk);
			t++;
		end
		if (nreset !== 1'b0) begin
			$display("reset was not released within 20 cycles");
			fail = 1'b1;
			done = 1'b1;
		end
		while (!done) begin
			kind = stim[pos];
			if (kind === 64'hb) begin
				// start code 2 means the beat follows the previous one at once
				if (stim[pos+1] !== 64'h2) begin
					rng = next_random(rng);
					repeat (int'(rng[1:0])) idle_cycle();
				end
				drive_beat(stim[pos+1] != 64'h0, LEN_W'(stim[pos+2]), stim[pos+3]);
				pos += 4;
			end else if (kind === 64'he) begin
				for (int f = 0; f < NFIELDS; f++) begin
					exp_rec[f] = stim[pos+1+f];
				end
				exp_push = 1'b1;
				pushed++;
				pos += 1 + NFIELDS;
			end else begin
				if (kind !== 64'hd) begin
					$display("stim file holds an unknown record at word %0d", pos);
					fail = 1'b1;
				end
				done = 1'b1;
			end
		end
		t = 0;
		while (resolved_cnt != pushed && t < 10) begin
			idle_cycle();
			t++;
		end
		if (resolved_cnt != pushed) begin
			$display("timed out waiting for the last expected message");
			fail = 1'b1;
		end
		repeat (2) idle_cycle();
		$display("errors: %0d mismatches, %0d missing, %0d extra",
			mismatch_cnt, missing_cnt, extra_cnt);
		if (fail || mismatch_cnt + missing_cnt + extra_cnt != 0) begin
			$display("Result: FAILED");
		end else begin
			$display("Result: PASSED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== tb_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_checker #(
	parameter int NFIELDS = 11
) (
	input  logic                     clk,
	input  logic                     nreset,
	input  logic                     msg_v_i,
	input  logic [NFIELDS-1:0][63:0] act_i,
	input  logic                     exp_push_i,
	input  logic [NFIELDS-1:0][63:0] exp_rec_i,
	output int                       mismatch_cnt_o,
	output int                       missing_cnt_o,
	output int                       extra_cnt_o,
	output int                       resolved_cnt_o
);

	logic                     push_seen = 1'b0;
	logic [NFIELDS-1:0][63:0] held;
	int                       mismatches = 0;
	int                       missing = 0;
	int                       extra = 0;
	int                       resolved = 0;

	function automatic string field_name(input int idx);
		case (idx)
			0: return "msg_type_o";
			1: return "stock_locate_o";
			2: return "tracking_number_o";
			3: return "timestamp_o";
			4: return "order_ref_o";
			5: return "shares_o";
			6: return "match_number_o";
			7: return "buy_sell_o";
			8: return "stock_o";
			9: return "price_o";
			default: return "event_code_o";
		endcase
	endfunction

	// record comes with the last beat, so the pulse is due one cycle later
	always @(posedge clk) begin
		push_seen <= exp_push_i && !nreset;
		held      <= exp_rec_i;
	end

	// outputs only move on the rising edge
	always @(negedge clk) begin
		if (!nreset) begin
			if (push_seen && msg_v_i !== 1'b1) begin
				missing++;
				resolved++;
				$display("%0t: no message output in the cycle after its last beat", $time);
			end else if (!push_seen && msg_v_i !== 1'b0) begin
				extra++;
				$display("%0t: msg_v_o is not low although no message was completed", $time);
			end else if (push_seen) begin
				resolved++;
				for (int f = 0; f < NFIELDS; f++) begin
					if (act_i[f] !== held[f]) begin
						mismatches++;
						$display("mismatch at %0t: %s got %h expected %h",
							$time, field_name(f), act_i[f], held[f]);
					end
				end
			end
		end
	end

	assign mismatch_cnt_o = mismatches;
	assign missing_cnt_o  = missing;
	assign extra_cnt_o    = extra;
	assign resolved_cnt_o = resolved;

endmodule

`default_nettype wire

// ==== tb_clock.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
	parameter int PERIOD_NS    = 10,
	parameter int RESET_CYCLES = 2
) (
	output logic clk_o,
	output logic nreset_o
);

	initial begin
		clk_o = 1'b0;
		forever #(PERIOD_NS / 2) clk_o = ~clk_o;
	end

	// reset is active high and drops on a falling edge
	initial begin
		nreset_o = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk_o);
		@(negedge clk_o);
		nreset_o = 1'b0;
	end

endmodule

`default_nettype wire

// ==== itch_decoder_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module itch_decoder_top #(
	parameter int AXI_DATA_W = 64
) (
	input  logic                                     clk,
	input  logic                                     nreset,
	input  logic                                     valid_i,
	input  logic                                     start_i,
	input  logic [$clog2(AXI_DATA_W/8):0]            len_i,
	input  logic [AXI_DATA_W-1:0]                    data_i,
	output logic                                     msg_v_o,
	output itch_pkg::itch_msg_e                      msg_type_o,
	output logic [15:0]                              stock_locate_o,
	output logic [15:0]                              tracking_number_o,
	output logic [47:0]                              timestamp_o,
	output logic [63:0]                              order_ref_o,
	output logic [31:0]                              shares_o,
	output logic [63:0]                              match_number_o,
	output logic [7:0]                               buy_sell_o,
	output logic [63:0]                              stock_o,
	output logic [31:0]                              price_o,
	output logic [7:0]                               event_code_o
);

	logic [itch_pkg::MSG_CNT_W-1:0]                       msg_bytes;
	logic [itch_pkg::MSG_MAX_BYTES*itch_pkg::BYTE_W-1:0] msg_data;
	logic                                                 msg_done;

	beat_if    #(.AXI_DATA_W(AXI_DATA_W)) bif ();
	aligned_if #(.AXI_DATA_W(AXI_DATA_W)) aif ();

	assign bif.valid = valid_i;
	assign bif.start = start_i;
	assign bif.len   = len_i;
	assign bif.data  = data_i;

	itch_beat_aligner #(.AXI_DATA_W(AXI_DATA_W)) u_aligner (
		.beat (bif.sink),
		.al   (aif.src)
	);

	itch_msg_assembler #(.AXI_DATA_W(AXI_DATA_W)) u_assembler (
		.clk         (clk),
		.nreset      (nreset),
		.al          (aif.dst),
		.msg_done_i  (msg_done),
		.msg_bytes_o (msg_bytes),
		.msg_data_o  (msg_data)
	);

	itch_msg_decoder u_decoder (
		.clk               (clk),
		.nreset            (nreset),
		.msg_bytes_i       (msg_bytes),
		.msg_data_i        (msg_data),
		.msg_done_o        (msg_done),
		.msg_v_o           (msg_v_o),
		.msg_type_o        (msg_type_o),
		.stock_locate_o    (stock_locate_o),
		.tracking_number_o (tracking_number_o),
		.timestamp_o       (timestamp_o),
		.order_ref_o       (order_ref_o),
		.shares_o          (shares_o),
		.match_number_o    (match_number_o),
		.buy_sell_o        (buy_sell_o),
		.stock_o           (stock_o),
		.price_o           (price_o),
		.event_code_o      (event_code_o)
	);

endmodule

`default_nettype wire

// ==== itch_msg_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module itch_msg_decoder (
	input  logic                                                 clk,
	input  logic                                                 nreset,
	input  logic [itch_pkg::MSG_CNT_W-1:0]                       msg_bytes_i,
	input  logic [itch_pkg::MSG_MAX_BYTES*itch_pkg::BYTE_W-1:0] msg_data_i,
	output logic                                                 msg_done_o,
	output logic                                                 msg_v_o,
	output itch_pkg::itch_msg_e                                  msg_type_o,
	output logic [15:0]                                          stock_locate_o,
	output logic [15:0]                                          tracking_number_o,
	output logic [47:0]                                          timestamp_o,
	output logic [63:0]                                          order_ref_o,
	output logic [31:0]                                          shares_o,
	output logic [63:0]                                          match_number_o,
	output logic [7:0]                                           buy_sell_o,
	output logic [63:0]                                          stock_o,
	output logic [31:0]                                          price_o,
	output logic [7:0]                                           event_code_o
);

	logic [7:0]                       type_byte;
	logic [itch_pkg::MSG_CNT_W-1:0]   msg_len;
	logic                             known;
	logic                             is_s;
	logic                             is_d;
	logic                             is_e;
	logic                             is_a;

	// big endian read of nbytes starting at byte ofs
	function automatic logic [63:0] be_field(
		input logic [itch_pkg::MSG_MAX_BYTES*itch_pkg::BYTE_W-1:0] data,
		input int ofs,
		input int nbytes
	);
		logic [63:0] r;
		r = '0;
		for (int i = 0; i < nbytes; i++) begin
			r = (r << itch_pkg::BYTE_W) | 64'(data[(ofs+i)*itch_pkg::BYTE_W +: itch_pkg::BYTE_W]);
		end
		return r;
	endfunction

	// type byte always sits at offset 0
	assign type_byte = msg_data_i[7:0];
	assign is_s  = (type_byte == itch_pkg::MSG_SYSTEM_EVENT);
	assign is_d  = (type_byte == itch_pkg::MSG_ORDER_DELETE);
	assign is_e  = (type_byte == itch_pkg::MSG_ORDER_EXECUTED);
	assign is_a  = (type_byte == itch_pkg::MSG_ADD_ORDER);
	assign known = is_s | is_d | is_e | is_a;

	always_comb begin
		msg_len = '0;
		if (is_s) msg_len = itch_pkg::MSG_CNT_W'(itch_pkg::LEN_SYSTEM_EVENT);
		if (is_d) msg_len = itch_pkg::MSG_CNT_W'(itch_pkg::LEN_ORDER_DELETE);
		if (is_e) msg_len = itch_pkg::MSG_CNT_W'(itch_pkg::LEN_ORDER_EXECUTED);
		if (is_a) msg_len = itch_pkg::MSG_CNT_W'(itch_pkg::LEN_ADD_ORDER);
	end

	assign msg_v_o    = known && (msg_bytes_i == msg_len);
	assign msg_done_o = msg_v_o;
	assign msg_type_o = itch_pkg::itch_msg_e'(type_byte);

	assign stock_locate_o    = known ? 16'(be_field(msg_data_i, itch_pkg::OFS_STOCK_LOCATE, 2)) : '0;
	assign tracking_number_o = known ? 16'(be_field(msg_data_i, itch_pkg::OFS_TRACKING, 2)) : '0;
	assign timestamp_o       = known ? 48'(be_field(msg_data_i, itch_pkg::OFS_TIMESTAMP, 6)) : '0;
	assign event_code_o      = is_s ? 8'(be_field(msg_data_i, itch_pkg::OFS_EVENT_CODE, 1)) : '0;
	assign order_ref_o       = (is_d | is_e | is_a) ? be_field(msg_data_i, itch_pkg::OFS_ORDER_REF, 8) : '0;
	assign match_number_o    = is_e ? be_field(msg_data_i, itch_pkg::OFS_MATCH, 8) : '0;
	assign buy_sell_o        = is_a ? 8'(be_field(msg_data_i, itch_pkg::OFS_BUY_SELL, 1)) : '0;
	assign stock_o           = is_a ? be_field(msg_data_i, itch_pkg::OFS_STOCK, 8) : '0;
	assign price_o           = is_a ? 32'(be_field(msg_data_i, itch_pkg::OFS_PRICE, 4)) : '0;

	// executed and add orders keep shares at different offsets
	assign shares_o = is_e ? 32'(be_field(msg_data_i, itch_pkg::OFS_EXEC_SHARES, 4)) :
	                  is_a ? 32'(be_field(msg_data_i, itch_pkg::OFS_ADD_SHARES, 4)) : '0;

	a_msg_v_known: assert property (@(posedge clk) disable iff (nreset) !$isunknown(msg_v_o));

endmodule

`default_nettype wire

// ==== itch_msg_assembler.sv ====
`timescale 1ns/1ps
`default_nettype none

module itch_msg_assembler #(
	parameter int AXI_DATA_W = 64
) (
	input  logic                                                 clk,
	input  logic                                                 nreset,
	aligned_if.dst                                               al,
	input  logic                                                 msg_done_i,
	output logic [itch_pkg::MSG_CNT_W-1:0]                       msg_bytes_o,
	output logic [itch_pkg::MSG_MAX_BYTES*itch_pkg::BYTE_W-1:0] msg_data_o
);

	localparam int BW        = itch_pkg::BYTE_W;
	localparam int CW        = itch_pkg::MSG_CNT_W;
	localparam int KEEP_W    = AXI_DATA_W / BW;
	localparam int OFS_W     = $clog2(KEEP_W);
	localparam int WORDS     = (itch_pkg::MSG_MAX_BYTES + KEEP_W - 1) / KEEP_W;
	localparam int CNT_LIMIT = itch_pkg::MSG_MAX_BYTES + KEEP_W;

	logic [CW-1:0]                     cnt_q;
	logic [CW-1:0]                     beat_len;
	logic [CW-1:0]                     base;
	logic [CW-1:0]                     word_idx;
	logic [WORDS-1:0]                  wr_lo;
	logic [WORDS-1:0]                  wr_hi;
	logic [WORDS-1:0][AXI_DATA_W-1:0]  store_q;
	logic [WORDS*AXI_DATA_W-1:0]       store_flat;

	// mask is contiguous so its popcount is the beat length
	assign beat_len = CW'($countones(al.mask_al));
	assign base     = al.start ? '0 : cnt_q;
	assign word_idx = base >> OFS_W;
	assign al.byte_ofs = base[OFS_W-1:0];

	always_ff @(posedge clk) begin
		if (nreset) begin
			cnt_q <= '0;
		end else if (al.valid && al.start) begin
			cnt_q <= beat_len;
		end else if (msg_done_i) begin
			cnt_q <= '0;
		end else if (al.valid && cnt_q <= itch_pkg::MSG_MAX_BYTES) begin
			// unknown types stop counting once past the store
			cnt_q <= cnt_q + beat_len;
		end
	end

	// lower half of the window lands in the start word, upper half in the next
	always_comb begin
		for (int w = 0; w < WORDS; w++) begin
			wr_lo[w] = al.valid && (word_idx == CW'(w));
			wr_hi[w] = al.valid && (word_idx + CW'(1) == CW'(w)) && |al.mask_al[2*KEEP_W-1:KEEP_W];
		end
	end

	// cleared store holds no valid type byte
	always_ff @(posedge clk) begin
		if (nreset) begin
			store_q <= '0;
		end else begin
			for (int w = 0; w < WORDS; w++) begin
				for (int b = 0; b < KEEP_W; b++) begin
					if (wr_lo[w] && al.mask_al[b]) begin
						store_q[w][b*BW +: BW] <= al.data_al[b*BW +: BW];
					end else if (wr_hi[w] && al.mask_al[KEEP_W+b]) begin
						store_q[w][b*BW +: BW] <= al.data_al[AXI_DATA_W + b*BW +: BW];
					end
				end
			end
		end
	end

	assign store_flat  = store_q;
	assign msg_data_o  = store_flat[itch_pkg::MSG_MAX_BYTES*BW-1:0];
	assign msg_bytes_o = cnt_q;

	a_wr_lo_onehot0: assert property (@(posedge clk) disable iff (nreset) $onehot0(wr_lo));
	a_wr_hi_onehot0: assert property (@(posedge clk) disable iff (nreset) $onehot0(wr_hi));
	a_cnt_bound: assert property (@(posedge clk) disable iff (nreset) cnt_q <= CNT_LIMIT);

endmodule

`default_nettype wire

// ==== itch_beat_aligner.sv ====
`timescale 1ns/1ps
`default_nettype none

module itch_beat_aligner #(
	parameter int AXI_DATA_W = 64
) (
	beat_if.sink   beat,
	aligned_if.src al
);

	localparam int KEEP_W = AXI_DATA_W / itch_pkg::BYTE_W;

	logic [KEEP_W-1:0]       len_mask;
	logic [2*AXI_DATA_W-1:0] data_ext;
	logic [2*KEEP_W-1:0]     mask_ext;

	// len counts valid bytes from bit 7:0 upwards
	always_comb begin
		for (int b = 0; b < KEEP_W; b++) begin
			len_mask[b] = (b < int'(beat.len));
		end
	end

	// upper word starts empty and catches bytes that cross the word boundary
	assign data_ext = {{AXI_DATA_W{1'b0}}, beat.data};
	assign mask_ext = {{KEEP_W{1'b0}}, len_mask};

	assign al.valid   = beat.valid;
	assign al.start   = beat.start;
	assign al.data_al = data_ext << (al.byte_ofs * itch_pkg::BYTE_W);
	assign al.mask_al = mask_ext << al.byte_ofs;

endmodule

`default_nettype wire

// ==== itch_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface beat_if #(parameter int AXI_DATA_W = 64);
	localparam int KEEP_W = AXI_DATA_W / itch_pkg::BYTE_W;
	localparam int LEN_W  = $clog2(KEEP_W) + 1;

	logic                  valid;
	logic                  start;
	logic [LEN_W-1:0]      len;
	logic [AXI_DATA_W-1:0] data;

	modport sink (input valid, input start, input len, input data);
endinterface

interface aligned_if #(parameter int AXI_DATA_W = 64);
	localparam int KEEP_W = AXI_DATA_W / itch_pkg::BYTE_W;
	localparam int OFS_W  = $clog2(KEEP_W);

	logic                    valid;
	logic                    start;
	logic [2*AXI_DATA_W-1:0] data_al;
	logic [2*KEEP_W-1:0]     mask_al;
	// write position inside the current store word
	logic [OFS_W-1:0]        byte_ofs;

	modport src (output valid, output start, output data_al, output mask_al, input byte_ofs);
	modport dst (input valid, input start, input data_al, input mask_al, output byte_ofs);
endinterface

`default_nettype wire

// ==== itch_pkg.sv ====
`default_nettype none

package itch_pkg;

	localparam int BYTE_W = 8;

	// longest kept message is add order
	localparam int MSG_MAX_BYTES = 36;

	// room for a full message plus one beat of overrun
	localparam int MSG_CNT_W = $clog2(2 * MSG_MAX_BYTES + 1);

	// values are the ascii type bytes on the wire
	typedef enum logic [7:0] {
		MSG_SYSTEM_EVENT   = 8'h53,
		MSG_ORDER_DELETE   = 8'h44,
		MSG_ORDER_EXECUTED = 8'h45,
		MSG_ADD_ORDER      = 8'h41
	} itch_msg_e;

	localparam int LEN_SYSTEM_EVENT   = 12;
	localparam int LEN_ORDER_DELETE   = 19;
	localparam int LEN_ORDER_EXECUTED = 31;
	localparam int LEN_ADD_ORDER      = 36;

	// common header
	localparam int OFS_STOCK_LOCATE = 1;
	localparam int OFS_TRACKING     = 3;
	localparam int OFS_TIMESTAMP    = 5;

	// type specific
	localparam int OFS_EVENT_CODE  = 11;
	localparam int OFS_ORDER_REF   = 11;
	localparam int OFS_EXEC_SHARES = 19;
	localparam int OFS_MATCH       = 23;
	localparam int OFS_BUY_SELL    = 19;
	localparam int OFS_ADD_SHARES  = 20;
	localparam int OFS_STOCK       = 24;
	localparam int OFS_PRICE       = 32;

endpackage

`default_nettype wire
